//--- Makefile
VERILATOR ?= verilator
TOP       ?= memSubsystemTb
FILELIST  ?= verilog.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# the log decides pass or fail
run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- src/byteRam.sv
`timescale 1ns/1ps
`default_nettype none

module byteRam (
    input  logic            clk,
    input  memPkg::ramPortT ram,
    output memPkg::byteT    rdByte
);
    import memPkg::*;

    byteT mem [memSize];

    // write port
    always_ff @(posedge clk) begin
        if (ram.we) begin
            mem[ram.addr] <= ram.wdata;
        end
    end

    // registered read every cycle
    // a same-address write returns the old byte
    always_ff @(posedge clk) begin
        rdByte <= mem[ram.addr];
    end

endmodule

`default_nettype wire

//--- src/instFetch.sv
`timescale 1ns/1ps
`default_nettype none

module instFetch (
    input  logic         clk,
    input  logic         rst,
    input  logic         start,
    input  memPkg::addrT startPc,
    input  logic         stop,
    output logic         fetchEn,
    output memPkg::addrT fetchAddr,
    input  logic         fetchDone,
    input  memPkg::wordT fetchInst,
    output logic         instValid,
    output memPkg::addrT instPc,
    output memPkg::wordT inst
);
    import memPkg::*;

    addrT pc;
    logic running;
    logic busy;
    logic issue;

    // next request leaves in the cycle after the previous word returns
    assign issue = running && !stop && (!busy || fetchDone);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc      <= '0;
            running <= 1'b0;
            busy    <= 1'b0;
            fetchEn <= 1'b0;
        end else begin
            fetchEn <= issue;

            if (issue) begin
                busy <= 1'b1;
            end else if (fetchDone) begin
                busy <= 1'b0;
            end

            if (start) begin
                running <= 1'b1;
            end else if (stop) begin
                running <= 1'b0;
            end

            if (start) begin
                pc <= startPc;
            end else if (fetchDone) begin
                pc <= pc + addrT'(4);
            end
        end
    end

    assign fetchAddr = pc;

    // pc still points at the returning word during fetchDone
    assign instValid = fetchDone;
    assign instPc    = pc;
    assign inst      = fetchInst;

endmodule

`default_nettype wire

//--- src/memCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module memCtrl (
    input  logic            clk,
    input  logic            rst,
    input  logic            ioBufferFull,
    // data port
    input  logic            dataEn,
    input  memPkg::dataReqT dataReq,
    output logic            dataDone,
    output memPkg::wordT    rdata,
    // fetch port
    input  logic            fetchEn,
    input  memPkg::addrT    fetchAddr,
    output logic            fetchDone,
    output memPkg::wordT    fetchInst,
    // byte RAM
    output memPkg::ramPortT ram,
    input  memPkg::byteT    rdByte
);
    import memPkg::*;

    ctrlStateT  state;
    lenT        stage;
    lenT        len;
    addrT       addr;
    wordT       data;

    logic       pendData;
    dataReqT    pendReq;
    logic       pendFetch;
    addrT       pendAddr;

    logic       dataValid;
    dataReqT    dataSel;
    logic       fetchValid;
    addrT       fetchSel;
    logic       takeData;
    logic       takeFetch;
    logic       reading;
    logic       lastRead;
    logic       lastWrite;
    lenT        offset;
    logic [1:0] capIdx;
    wordT       assembled;

    assign dataValid  = pendData | dataEn;
    assign dataSel    = pendData ? pendReq : dataReq;
    assign fetchValid = pendFetch | fetchEn;
    assign fetchSel   = pendFetch ? pendAddr : fetchAddr;

    // grant in idle only, data wins over fetch
    assign takeData  = (state == idle) && !ioBufferFull && dataValid;
    assign takeFetch = (state == idle) && !ioBufferFull && !dataValid && fetchValid;

    assign reading   = (state == readInst) || (state == readData);
    assign lastRead  = reading && (stage == len);
    assign lastWrite = (state == writeData) && (stage == len - 3'd1);

    // on a stall the previous byte address goes out again,
    // so rdByte still holds the byte owed to the current stage
    assign offset = (ioBufferFull && stage != 3'd0) ? stage - 3'd1 : stage;

    // rdByte belongs to the address of the previous stage
    assign capIdx = 2'(stage - 3'd1);

    always_comb begin
        assembled = data;
        assembled[{capIdx, 3'b000} +: 8] = rdByte;
    end

    always_comb begin
        ram.we    = (state == writeData) && !ioBufferFull;
        ram.addr  = addr + addrT'(offset);
        ram.wdata = data[{stage[1:0], 3'b000} +: 8];
    end

    // sequencer and handshake control
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= idle;
            stage     <= '0;
            pendData  <= 1'b0;
            pendFetch <= 1'b0;
            dataDone  <= 1'b0;
            fetchDone <= 1'b0;
        end else begin
            dataDone  <= 1'b0;
            fetchDone <= 1'b0;

            // strobes not granted this cycle wait here
            if (takeData) begin
                pendData <= 1'b0;
            end else if (dataEn) begin
                pendData <= 1'b1;
            end
            if (takeFetch) begin
                pendFetch <= 1'b0;
            end else if (fetchEn) begin
                pendFetch <= 1'b1;
            end

            if (!ioBufferFull) begin
                case (state)
                    idle: begin
                        stage <= '0;
                        if (takeData) begin
                            state <= dataSel.store ? writeData : readData;
                        end else if (takeFetch) begin
                            state <= readInst;
                        end
                    end
                    readInst, readData: begin
                        if (lastRead) begin
                            state <= idle;
                            stage <= '0;
                            if (state == readInst) begin
                                fetchDone <= 1'b1;
                            end else begin
                                dataDone <= 1'b1;
                            end
                        end else begin
                            stage <= stage + 3'd1;
                        end
                    end
                    writeData: begin
                        if (lastWrite) begin
                            state    <= idle;
                            stage    <= '0;
                            dataDone <= 1'b1;
                        end else begin
                            stage <= stage + 3'd1;
                        end
                    end
                endcase
            end
        end
    end

    // request payload and byte assembly
    always_ff @(posedge clk) begin
        if (dataEn) begin
            pendReq <= dataReq;
        end
        if (fetchEn) begin
            pendAddr <= fetchAddr;
        end

        if (takeData) begin
            addr <= dataSel.addr;
            len  <= dataSel.len;
            data <= dataSel.store ? dataSel.wdata : '0;
        end else if (takeFetch) begin
            addr <= fetchSel;
            len  <= fetchLen;
            data <= '0;
        end else if (!ioBufferFull && reading && stage != 3'd0) begin
            data <= assembled;
        end

        // zero-extension comes from clearing data at grant
        if (!ioBufferFull && lastRead) begin
            if (state == readInst) begin
                fetchInst <= assembled;
            end else begin
                rdata <= assembled;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/memPkg.sv
`default_nettype none

package memPkg;

    localparam int addrW = 17;
    localparam int byteW = 8;
    localparam int wordW = 32;
    localparam int lenW  = 3;

    // one byte per address over the whole 17-bit space
    localparam int memSize = 131072;

    typedef logic [addrW-1:0] addrT;
    typedef logic [byteW-1:0] byteT;
    typedef logic [wordW-1:0] wordT;
    typedef logic [lenW-1:0]  lenT;

    // fetches always move a whole instruction
    localparam lenT fetchLen = 3'd4;

    typedef enum logic [1:0] {
        idle,
        readInst,
        readData,
        writeData
    } ctrlStateT;

    typedef struct packed {
        logic store;
        lenT  len;
        addrT addr;
        wordT wdata;
    } dataReqT;

    typedef struct packed {
        logic we;
        addrT addr;
        byteT wdata;
    } ramPortT;

endpackage

`default_nettype wire

//--- src/memSubsystem.sv
`timescale 1ns/1ps
`default_nettype none

module memSubsystem (
    input  logic            clk,
    input  logic            rst,
    input  logic            ioBufferFull,
    input  logic            dataEn,
    input  memPkg::dataReqT dataReq,
    output logic            dataDone,
    output memPkg::wordT    rdata,
    input  logic            start,
    input  memPkg::addrT    startPc,
    input  logic            stop,
    output logic            instValid,
    output memPkg::addrT    instPc,
    output memPkg::wordT    inst
);
    import memPkg::*;

    logic    fetchEn;
    addrT    fetchAddr;
    logic    fetchDone;
    wordT    fetchInst;
    ramPortT ram;
    byteT    rdByte;

    instFetch fetchUnit (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .startPc   (startPc),
        .stop      (stop),
        .fetchEn   (fetchEn),
        .fetchAddr (fetchAddr),
        .fetchDone (fetchDone),
        .fetchInst (fetchInst),
        .instValid (instValid),
        .instPc    (instPc),
        .inst      (inst)
    );

    memCtrl ctrl (
        .clk          (clk),
        .rst          (rst),
        .ioBufferFull (ioBufferFull),
        .dataEn       (dataEn),
        .dataReq      (dataReq),
        .dataDone     (dataDone),
        .rdata        (rdata),
        .fetchEn      (fetchEn),
        .fetchAddr    (fetchAddr),
        .fetchDone    (fetchDone),
        .fetchInst    (fetchInst),
        .ram          (ram),
        .rdByte       (rdByte)
    );

    byteRam ramInst (
        .clk    (clk),
        .ram    (ram),
        .rdByte (rdByte)
    );

endmodule

`default_nettype wire

//--- tests/memCtrlAsserts.sv
`timescale 1ns/1ps
`default_nettype none

module memCtrlAsserts (
    input logic            clk,
    input logic            rst,
    input logic            ioBufferFull,
    input logic            dataDone,
    input logic            fetchDone,
    input memPkg::ramPortT ram
);

    // the two ports never finish together
    doneExclusive: assert property (@(posedge clk) disable iff (rst) !(dataDone && fetchDone))
        else $error("dataDone and fetchDone high in the same cycle");

    dataDonePulse: assert property (@(posedge clk) disable iff (rst) dataDone |=> !dataDone)
        else $error("dataDone held longer than one cycle");

    fetchDonePulse: assert property (@(posedge clk) disable iff (rst) fetchDone |=> !fetchDone)
        else $error("fetchDone held longer than one cycle");

    // a frozen sequencer must not touch the RAM
    noWriteInStall: assert property (@(posedge clk) disable iff (rst) ioBufferFull |-> !ram.we)
        else $error("RAM write while ioBufferFull is high");

endmodule

bind memCtrl memCtrlAsserts ctrlChecks (
    .clk          (clk),
    .rst          (rst),
    .ioBufferFull (ioBufferFull),
    .dataDone     (dataDone),
    .fetchDone    (fetchDone),
    .ram          (ram)
);

`default_nettype wire

//--- tests/memSubsystemTb.sv
`timescale 1ns/1ps
`default_nettype none

module memSubsystemTb;
    import memPkg::*;

    typedef enum logic [1:0] {opStore, opLoad, opFetch, opArb} opT;

    // len counts words on fetch rows
    // wdata carries the fetch pc on arb rows
    typedef struct packed {
        opT         op;
        lenT        len;
        addrT       addr;
        wordT       wdata;
        logic [3:0] stalls;
    } rowT;

    localparam int numRows = 22;
    localparam rowT rows [numRows] = '{
        '{opStore, 3'd4, 17'h00100, 32'h00000013, 4'd0},
        '{opStore, 3'd4, 17'h00104, 32'h00a00093, 4'd0},
        '{opStore, 3'd4, 17'h00108, 32'h01408113, 4'd0},
        '{opStore, 3'd4, 17'h0010c, 32'hfe010ee3, 4'd0},
        '{opStore, 3'd1, 17'h00200, 32'hffffffa5, 4'd0},
        '{opStore, 3'd1, 17'h00201, 32'h77777742, 4'd0},
        '{opStore, 3'd2, 17'h00202, 32'h1111beef, 4'd0},
        '{opStore, 3'd4, 17'h00204, 32'hcafef00d, 4'd0},
        '{opLoad,  3'd1, 17'h00200, 32'h00000000, 4'd0},
        '{opLoad,  3'd2, 17'h00202, 32'h00000000, 4'd0},
        '{opLoad,  3'd4, 17'h00200, 32'h00000000, 4'd0},
        '{opLoad,  3'd2, 17'h00203, 32'h00000000, 4'd0},
        '{opLoad,  3'd1, 17'h00207, 32'h00000000, 4'd0},
        '{opStore, 3'd1, 17'h00205, 32'h0000003c, 4'd2},
        '{opStore, 3'd2, 17'h1fffe, 32'h000055aa, 4'd1},
        '{opLoad,  3'd4, 17'h00204, 32'h00000000, 4'd2},
        '{opLoad,  3'd2, 17'h1fffe, 32'h00000000, 4'd3},
        '{opStore, 3'd4, 17'h00300, 32'h89abcdef, 4'd3},
        '{opLoad,  3'd4, 17'h00300, 32'h00000000, 4'd2},
        '{opLoad,  3'd1, 17'h00302, 32'h00000000, 4'd1},
        '{opFetch, 3'd4, 17'h00100, 32'h00000000, 4'd0},
        '{opArb,   3'd4, 17'h00204, 32'h00000108, 4'd0}
    };

    logic    clk;
    logic    rst;
    logic    ioBufferFull;
    logic    dataEn;
    dataReqT dataReq;
    logic    dataDone;
    wordT    rdata;
    logic    start;
    addrT    startPc;
    logic    stop;
    logic    instValid;
    addrT    instPc;
    wordT    inst;

    byteT        model [memSize];
    logic [31:0] lfsr;
    int          errors;
    int          failures;

    memSubsystem UUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic compareValue(input string name, input wordT got, input wordT exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR: %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    // fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic drawBits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrNext(lfsr);
            val = (val << 1) | int'(lfsr[0]);
        end
    endtask

    // little-endian word from the reference bytes
    function automatic wordT modelWord(input addrT a, input int n);
        wordT w;
        w = '0;
        for (int i = 0; i < n; i++) begin
            w[8*i +: 8] = model[a + addrT'(i)];
        end
        return w;
    endfunction

    // counts edges until dataDone and inserts random stall pulses
    task automatic waitDataDone(input int pulses, output int cycles, output int stalled);
        int runLeft;
        int gap;
        int v;
        runLeft = 0;
        stalled = 0;
        cycles = 0;
        drawBits(1, gap);
        while (!dataDone && cycles < 100) begin
            if (runLeft == 0 && gap == 0 && pulses > 0) begin
                drawBits(2, v);
                runLeft = v + 1;
                pulses--;
                gap = 1;
            end else if (runLeft == 0) begin
                gap = 0;
            end
            ioBufferFull = (runLeft > 0);
            if (runLeft > 0) begin
                runLeft--;
                stalled++;
            end
            @(posedge clk);
            #1;
            cycles++;
        end
        ioBufferFull = 1'b0;
        if (!dataDone) begin
            failures++;
            $display("timeout: dataDone did not arrive within %0d cycles", cycles);
        end
    endtask

    task automatic waitInstValid(output int cycles);
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
        end while (!instValid && cycles < 100);
        if (!instValid) begin
            failures++;
            $display("timeout: no instruction word arrived within %0d cycles", cycles);
        end
    endtask

    task automatic expectQuiet(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            #1;
            if (dataDone || instValid) begin
                failures++;
                $display("a done or instValid pulse showed up with no request outstanding");
            end
        end
    endtask

    task automatic runData(input rowT row);
        int n;
        int cycles;
        int stalled;
        n = int'(row.len);
        dataReq = '{store: row.op == opStore, len: row.len, addr: row.addr, wdata: row.wdata};
        dataEn = 1'b1;
        @(posedge clk);
        #1;
        dataEn = 1'b0;
        waitDataDone(int'(row.stalls), cycles, stalled);
        if (row.op == opStore) begin
            for (int i = 0; i < n; i++) begin
                model[row.addr + addrT'(i)] = row.wdata[8*i +: 8];
            end
            compareValue("store dataDone latency", cycles, n + stalled);
        end else begin
            compareValue("rdata", rdata, modelWord(row.addr, n));
            compareValue("load dataDone latency", cycles, n + 1 + stalled);
        end
    endtask

    task automatic runFetch(input addrT pc, input int words);
        int cycles;
        startPc = pc;
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        for (int i = 0; i < words; i++) begin
            if (i == words - 1) begin
                // stop while the last fetch is in flight
                @(posedge clk);
                #1;
                stop = 1'b1;
                @(posedge clk);
                #1;
                stop = 1'b0;
            end
            waitInstValid(cycles);
            compareValue("fetch latency", cycles, (i == words - 1) ? 5 : 7);
            compareValue("instPc", wordT'(instPc), wordT'(pc + addrT'(4*i)));
            compareValue("inst", inst, modelWord(pc + addrT'(4*i), 4));
        end
        expectQuiet(12);
    endtask

    task automatic runArb(input rowT row);
        int n;
        int cycles;
        int stalled;
        addrT pc;
        n = int'(row.len);
        pc = row.wdata[addrW-1:0];
        startPc = pc;
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        waitInstValid(cycles);
        compareValue("inst", inst, modelWord(pc, 4));
        // load strobe lands in the same cycle as the next fetch strobe
        @(posedge clk);
        #1;
        dataReq = '{store: 1'b0, len: row.len, addr: row.addr, wdata: '0};
        dataEn = 1'b1;
        @(posedge clk);
        #1;
        dataEn = 1'b0;
        waitDataDone(0, cycles, stalled);
        compareValue("load dataDone latency", cycles, n + 1);
        compareValue("rdata", rdata, modelWord(row.addr, n));
        waitInstValid(cycles);
        compareValue("fetch latency after load", cycles, 6);
        compareValue("instPc", wordT'(instPc), wordT'(pc + addrT'(4)));
        compareValue("inst", inst, modelWord(pc + addrT'(4), 4));
        stop = 1'b1;
        @(posedge clk);
        #1;
        stop = 1'b0;
        expectQuiet(12);
    endtask

    initial begin
        lfsr = 32'hac7b;
        errors = 0;
        failures = 0;
        rst = 1'b1;
        ioBufferFull = 1'b0;
        dataEn = 1'b0;
        dataReq = '0;
        start = 1'b0;
        startPc = '0;
        stop = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        expectQuiet(8);
        for (int r = 0; r < numRows; r++) begin
            case (rows[r].op)
                opStore, opLoad: runData(rows[r]);
                opFetch: runFetch(rows[r].addr, int'(rows[r].len));
                opArb: runArb(rows[r]);
            endcase
        end
        $display("mismatches: %0d, other failures: %0d", errors, failures);
        if (errors == 0 && failures == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
src/memPkg.sv
src/byteRam.sv
src/memCtrl.sv
src/instFetch.sv
src/memSubsystem.sv
tests/memCtrlAsserts.sv
tests/memSubsystemTb.sv
